// File: src/arb_pkg.sv
/* shared sizes and bus structs for the four-client register bank.
   imported by every RTL block and by the testbench. */
package arb_pkg;

    localparam int num_clients  = 4;                    // bus masters.
    localparam int client_idx_w = $clog2(num_clients);  // 2 bits.
    localparam int addr_w       = 4;                    // 16 registers.
    localparam int data_w       = 16;

    // command a client holds stable while req is high.
    typedef struct packed {
        logic              write;  // 1 = write, 0 = read.
        logic [addr_w-1:0] addr;
        logic [data_w-1:0] wdata;  // ignored on reads.
    } bus_cmd_t;

    // response from the bank, valid while ack is high.
    typedef struct packed {
        logic [data_w-1:0] rdata;
    } bus_rsp_t;

endpackage

// File: src/priority_encoder.sv
/* combinational highest-set-bit encoder.
   gives a found flag, the binary index and a one-hot mask of the winner. */
module priority_encoder #(
    parameter int width = 4
) (
    input  logic [width-1:0]         in_bits,
    output logic                     valid,
    output logic [$clog2(width)-1:0] index,
    output logic [width-1:0]         one_hot
);

    // scan upward so the highest set bit is the last one kept.
    always_comb begin
        valid = 1'b0;
        index = '0;
        for (int i = 0; i < width; i++) begin
            if (in_bits[i]) begin
                valid = 1'b1;
                index = i[$clog2(width)-1:0];  // higher index wins.
            end
        end
    end

    // one-hot of the winner, zero when nothing is set.
    always_comb begin
        one_hot = '0;
        if (valid) begin
            one_hot[index] = 1'b1;
        end
    end

endmodule

// File: src/arbiter.sv
/* registered round-robin arbiter.
   holds a grant while its request stays high, then passes it on
   to the highest requester below the last owner. */
module arbiter (
    input  logic                             clk,
    input  logic                             rst,
    input  logic [arb_pkg::num_clients-1:0]  request,
    output logic [arb_pkg::num_clients-1:0]  grant,
    output logic                             grant_valid,
    output logic [arb_pkg::client_idx_w-1:0] grant_index
);
    import arb_pkg::*;

    logic [num_clients-1:0]  mask_reg;          // bits below last owner.
    logic [num_clients-1:0]  mask_next;
    logic [num_clients-1:0]  masked_request;
    logic [num_clients-1:0]  grant_next;
    logic                    grant_valid_next;
    logic [client_idx_w-1:0] grant_index_next;
    logic                    hold;

    logic                    req_valid;         // plain encoder.
    logic [client_idx_w-1:0] req_index;
    logic [num_clients-1:0]  req_one_hot;
    logic                    masked_valid;      // masked encoder.
    logic [client_idx_w-1:0] masked_index;
    logic [num_clients-1:0]  masked_one_hot;

    assign masked_request = request & mask_reg;

    priority_encoder #(
        .width(num_clients)
    ) u_enc_plain (
        .in_bits(request),
        .valid  (req_valid),
        .index  (req_index),
        .one_hot(req_one_hot)
    );

    priority_encoder #(
        .width(num_clients)
    ) u_enc_masked (
        .in_bits(masked_request),
        .valid  (masked_valid),
        .index  (masked_index),
        .one_hot(masked_one_hot)
    );

    // owner still busy while its req is up.
    assign hold = grant_valid && |(grant & request);

    always_comb begin
        grant_next       = '0;
        grant_valid_next = 1'b0;
        grant_index_next = '0;
        mask_next        = mask_reg;
        if (hold) begin
            grant_next       = grant;       // keep the bus.
            grant_valid_next = 1'b1;
            grant_index_next = grant_index;
        end else if (masked_valid) begin
            // someone below the last owner is waiting.
            grant_next       = masked_one_hot;
            grant_valid_next = 1'b1;
            grant_index_next = masked_index;
            mask_next        = masked_one_hot - 1'b1;
        end else if (req_valid) begin
            // wrap around to the top requester.
            grant_next       = req_one_hot;
            grant_valid_next = 1'b1;
            grant_index_next = req_index;
            mask_next        = req_one_hot - 1'b1;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            grant       <= '0;
            grant_valid <= 1'b0;
            grant_index <= '0;
            mask_reg    <= '0;  // first grant goes to the highest requester.
        end else begin
            grant       <= grant_next;
            grant_valid <= grant_valid_next;
            grant_index <= grant_index_next;
            mask_reg    <= mask_next;
        end
    end

endmodule

// File: src/bus_switch.sv
/* combinational bus switch between the clients and one target.
   the granted client alone drives the target and alone sees its ack;
   the payload type is opaque here and set by the instantiating level. */
module bus_switch #(
    parameter type payload_t = logic
) (
    input  logic [arb_pkg::num_clients-1:0]  client_req,
    input  payload_t                         client_payload [arb_pkg::num_clients],
    output logic [arb_pkg::num_clients-1:0]  client_ack,
    input  logic [arb_pkg::num_clients-1:0]  grant,
    input  logic                             grant_valid,
    input  logic [arb_pkg::client_idx_w-1:0] grant_index,
    output logic                             tgt_req,
    output payload_t                         tgt_payload,
    input  logic                             tgt_ack
);
    import arb_pkg::*;

    logic                   owner_req;      // req of the granted client.
    logic [num_clients-1:0] ack_route;

    // request path, indexed by the binary grant.
    assign owner_req = client_req[grant_index];

    // no owner, no target request.
    assign tgt_req = grant_valid && owner_req;

    // payload follows the owner.
    // target ignores it while tgt_req is low.
    assign tgt_payload = client_payload[grant_index];

    // ack goes back on the one-hot grant line.
    always_comb begin
        ack_route = '0;
        for (int i = 0; i < num_clients; i++) begin
            ack_route[i] = grant[i] && tgt_ack;
        end
    end

    // others never see an ack.
    assign client_ack = grant_valid ? ack_route : '0;

endmodule

// File: src/reg_bank.sv
/* 16 x 16-bit register file behind a four-phase req/ack slave port.
   the access happens on the edge that raises ack; rsp holds until the next one. */
module reg_bank (
    input  logic              clk,
    input  logic              rst,
    input  logic              req,
    input  arb_pkg::bus_cmd_t cmd,
    output logic              ack,
    output arb_pkg::bus_rsp_t rsp
);
    import arb_pkg::*;

    logic [data_w-1:0] regs [2**addr_w];  // register storage.
    logic              start;             // new transfer this edge.

    // fresh request only once the previous ack is gone.
    assign start = req && !ack;

    // handshake state.
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ack <= 1'b0;
        end else if (start) begin
            ack <= 1'b1;  // done in one edge.
        end else if (!req) begin
            ack <= 1'b0;  // return to zero.
        end
    end

    // storage and read data.
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < 2**addr_w; i++) begin
                regs[i] <= '0;
            end
            rsp <= '0;
        end else if (start) begin
            if (cmd.write) begin
                regs[cmd.addr] <= cmd.wdata;
                rsp.rdata      <= cmd.wdata;  // echo written value.
            end else begin
                rsp.rdata <= regs[cmd.addr];
            end
        end
    end

endmodule

// File: src/shared_bus_top.sv
/* four clients sharing one register bank.
   arbiter picks the owner, the switch gives it the bank. */
module shared_bus_top (
    input  logic                            clk,
    input  logic                            rst,
    input  logic [arb_pkg::num_clients-1:0] client_req,
    input  arb_pkg::bus_cmd_t               client_cmd [arb_pkg::num_clients],
    output logic [arb_pkg::num_clients-1:0] client_ack,
    output arb_pkg::bus_rsp_t               rsp
);
    import arb_pkg::*;

    logic [num_clients-1:0]  grant;
    logic                    grant_valid;
    logic [client_idx_w-1:0] grant_index;
    logic                    tgt_req;
    logic                    tgt_ack;
    bus_cmd_t                tgt_cmd;

    arbiter u_arbiter (
        .clk        (clk),
        .rst        (rst),
        .request    (client_req),
        .grant      (grant),
        .grant_valid(grant_valid),
        .grant_index(grant_index)
    );

    bus_switch #(
        .payload_t(bus_cmd_t)
    ) u_switch (
        .client_req    (client_req),
        .client_payload(client_cmd),
        .client_ack    (client_ack),
        .grant         (grant),
        .grant_valid   (grant_valid),
        .grant_index   (grant_index),
        .tgt_req       (tgt_req),
        .tgt_payload   (tgt_cmd),
        .tgt_ack       (tgt_ack)
    );

    reg_bank u_bank (
        .clk(clk),
        .rst(rst),
        .req(tgt_req),
        .cmd(tgt_cmd),
        .ack(tgt_ack),
        .rsp(rsp)
    );

endmodule

// File: tests/tb_clock.sv
/* testbench clock and reset source.
   period 10, reset high for the first 4 cycles. */
module tb_clock (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;  // 10 unit period.
    end

    initial begin
        rst = 1'b1;
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;  // released away from the active edge.
    end

endmodule

// File: tests/tb_shared_bus.sv
/* testbench for the four-client shared register bank.
   client drivers run in parallel; a monitor checks acks, read data and grant order. */
module tb_shared_bus;
    import arb_pkg::*;

    localparam int timeout_edges = 100;  // per wait loop.

    logic                   clk;
    logic                   rst;
    logic [num_clients-1:0] client_req;
    bus_cmd_t               client_cmd [num_clients];
    logic [num_clients-1:0] client_ack;
    bus_rsp_t               rsp;

    logic [data_w-1:0]      model_regs [2**addr_w];  // reference, updated in ack order.
    logic [num_clients-1:0] prev_ack;                // last post-edge sample.
    logic [num_clients-1:0] prev_req;
    int                     last_owner;
    int                     owner_log [$];           // ack owners, oldest first.
    int                     checks;
    int                     errors;

    tb_clock u_clock (
        .clk(clk),
        .rst(rst)
    );

    shared_bus_top u_dut (
        .clk       (clk),
        .rst       (rst),
        .client_req(client_req),
        .client_cmd(client_cmd),
        .client_ack(client_ack),
        .rsp       (rsp)
    );

    task automatic compare_value(input string name, input int expected, input int actual);
        checks++;
        assert (expected == actual) else begin
            errors++;
            $display("Fail %s: expected %0h, got %0h", name, expected, actual);
        end
    endtask

    // highest requester below the last owner, else the highest one overall.
    function automatic int predict_owner(input logic [num_clients-1:0] req, input int last);
        int pick;
        pick = -1;
        for (int i = 0; i < num_clients; i++) begin
            if (req[client_idx_w'(i)] && i < last) pick = i;
        end
        if (pick < 0) begin
            for (int i = 0; i < num_clients; i++) begin
                if (req[client_idx_w'(i)]) pick = i;
            end
        end
        return pick;
    endfunction

    // runs one four-phase cycle and counts edges to ack rise and fall.
    task automatic do_xfer(input logic [client_idx_w-1:0] c, input logic wr,
                           input logic [addr_w-1:0] a, input logic [data_w-1:0] wd,
                           output int rise_edges, output int fall_edges);
        @(negedge clk);
        client_cmd[c] = '{write: wr, addr: a, wdata: wd};  // stable while req is up.
        client_req[c] = 1'b1;
        rise_edges = 0;
        do begin
            @(posedge clk);
            #1;  // look after the edge settles.
            rise_edges++;
        end while (!client_ack[c] && rise_edges < timeout_edges);
        if (!client_ack[c]) begin
            errors++;
            $display("client %0d timed out waiting for ack to rise", c);
        end
        @(negedge clk);
        client_req[c] = 1'b0;
        fall_edges = 0;
        do begin
            @(posedge clk);
            #1;
            fall_edges++;
        end while (client_ack[c] && fall_edges < timeout_edges);
        if (client_ack[c]) begin
            errors++;
            $display("client %0d timed out waiting for ack to fall", c);
        end
    endtask

    // mode 0 writes, 1 reads, anything else mixed.
    task automatic run_client(input logic [client_idx_w-1:0] c, input int n, input int mode);
        logic              wr;
        logic [addr_w-1:0] a;
        logic [data_w-1:0] wd;
        int                rise_edges;
        int                fall_edges;
        for (int k = 0; k < n; k++) begin
            a  = addr_w'($urandom);
            wd = data_w'($urandom);
            case (mode)
                0:       wr = 1'b1;
                1:       wr = 1'b0;
                default: wr = 1'($urandom);
            endcase
            do_xfer(c, wr, a, wd, rise_edges, fall_edges);
        end
    endtask

    // idle bus only.
    task automatic verify_latency(input int rise_edges, input int fall_edges);
        compare_value("latency_rise", 2, rise_edges);
        checks++;
        assert (fall_edges <= 2) else begin
            errors++;
            $display("Fail latency_fall: expected <= 2, got %0d", fall_edges);
        end
    endtask

    task automatic match_order(input string name, input int order [5]);
        for (int i = 0; i < 5; i++) begin
            if (i < owner_log.size()) begin
                compare_value($sformatf("%s[%0d]", name, i), order[i], owner_log[i]);
            end else begin
                errors++;
                $display("%s saw only %0d grants, fewer than 5", name, owner_log.size());
                break;
            end
        end
    endtask

    // bus monitor sampling one time unit after each rising edge.
    initial begin
        logic [client_idx_w-1:0] idx;
        int                      expect_owner;
        prev_ack   = '0;
        prev_req   = '0;
        last_owner = 0;  // empty mask after reset.
        forever begin
            @(posedge clk);
            #1;
            if (!rst) begin
                checks++;
                assert ($countones(client_ack) <= 1) else begin
                    errors++;
                    $display("more than one client ack high at once: %b", client_ack);
                end
                for (int i = 0; i < num_clients; i++) begin
                    idx = client_idx_w'(i);
                    if (client_ack[idx] && !prev_ack[idx]) begin
                        checks++;
                        assert (client_req[idx]) else begin
                            errors++;
                            $display("ack rose for client %0d while its req was low", i);
                        end
                        // grant was decided one edge earlier.
                        expect_owner = predict_owner(prev_req, last_owner);
                        compare_value("grant_order", expect_owner, i);
                        last_owner = i;
                        owner_log.push_back(i);
                        if (client_cmd[idx].write) begin
                            model_regs[client_cmd[idx].addr] = client_cmd[idx].wdata;
                        end else begin
                            compare_value($sformatf("read_r%0d", client_cmd[idx].addr),
                                          int'(model_regs[client_cmd[idx].addr]),
                                          int'(rsp.rdata));
                        end
                    end
                end
                prev_ack = client_ack;
                prev_req = client_req;
            end
        end
    end

    initial begin
        int rise_edges;
        int fall_edges;
        int wait_edges;
        int order [5];
        void'($urandom(3));  // one seed for the run.
        checks     = 0;
        errors     = 0;
        client_req = '0;
        client_cmd = '{default: '0};
        model_regs = '{default: '0};

        wait_edges = 0;
        do begin
            @(posedge clk);
            wait_edges++;
        end while (rst !== 1'b0 && wait_edges < timeout_edges);
        if (rst !== 1'b0) begin
            errors++;
            $display("reset was never released");
        end
        @(posedge clk);
        #1;
        compare_value("reset_ack", 0, int'(client_ack));
        compare_value("reset_rsp", 0, int'(rsp.rdata));

        // every register reads zero, on an idle bus.
        for (int a = 0; a < 2**addr_w; a++) begin
            do_xfer(2'd0, 1'b0, addr_w'(a), '0, rise_edges, fall_edges);
            verify_latency(rise_edges, fall_edges);
        end

        // contended random writes, then reads.
        fork
            run_client(2'd0, 8, 0);
            run_client(2'd1, 8, 0);
            run_client(2'd2, 8, 0);
            run_client(2'd3, 8, 0);
        join
        fork
            run_client(2'd0, 8, 1);
            run_client(2'd1, 8, 1);
            run_client(2'd2, 8, 1);
            run_client(2'd3, 8, 1);
        join
        for (int a = 0; a < 2**addr_w; a++) begin
            do_xfer(2'd2, 1'b0, addr_w'(a), '0, rise_edges, fall_edges);
            verify_latency(rise_edges, fall_edges);
        end

        // client 0 owns last, so the next round starts from the top.
        do_xfer(2'd0, 1'b0, '0, '0, rise_edges, fall_edges);
        owner_log.delete();
        fork
            run_client(2'd0, 3, 2);
            run_client(2'd1, 3, 2);
            run_client(2'd2, 3, 2);
            run_client(2'd3, 3, 2);
        join
        order = '{3, 2, 1, 0, 3};
        match_order("rr_all", order);

        // only 1 and 3 active.
        owner_log.delete();
        fork
            run_client(2'd1, 3, 2);
            run_client(2'd3, 3, 2);
        join
        order = '{3, 1, 3, 1, 3};
        match_order("rr_pair", order);

        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

// File: flist.f
src/arb_pkg.sv
src/priority_encoder.sv
src/arbiter.sv
src/bus_switch.sv
src/reg_bank.sv
src/shared_bus_top.sv
tests/tb_clock.sv
tests/tb_shared_bus.sv

// File: run.sh
#!/bin/sh
# build and run the shared register bank testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --assert -j 0 --top-module tb_shared_bus -f flist.f -o sim_shared_bus
./obj_dir/sim_shared_bus > sim.log
cat sim.log

if grep -q "Some tests failed" sim.log; then
    echo "simulation reported failures"
    exit 1
fi
echo "simulation clean"
